// File: verilog/mem_settings.svh
/* Memory subsystem settings
   Avalon widths, burst length and word index width */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ########################################
// Avalon bus

`define MEM_ADDR_W 24 // Word address width of the DDR3 controller port
`define MEM_DATA_W 32 // Data width of one Avalon word

// ########################################
// Buffers

`define MEM_BURST_LEN 4 // Words per burst for the read buffers and the accumulator
`define MEM_IDX_W 2 // Enough bits to index every word of a burst

`endif

// File: verilog/avl_pkg.sv
/* Avalon bus types
   Address and data vectors plus the host and agent signal bundles */
`include "mem_settings.svh"

package avl_pkg;

	typedef logic [`MEM_ADDR_W-1:0] avl_addr_t; // Word address
	typedef logic [`MEM_DATA_W-1:0] avl_data_t; // One data word

	// ########################################
	// Signals driven by a host toward the DDR3 controller

	typedef struct packed {
		logic burstbegin; // High with the first beat of a burst
		avl_addr_t address;
		avl_data_t writedata;
		logic write;
		logic read;
	} avl_host_t;

	// ########################################
	// Signals driven by the DDR3 controller back to a host

	typedef struct packed {
		logic local_init_done; // Controller calibration finished
		logic readdatavalid; // Qualifies readdata, returned in order
		logic wait_request_n; // Low while the agent stalls the command
		avl_data_t readdata;
	} avl_agent_t;

endpackage

// File: verilog/buffer_pkg.sv
/* Buffer client types
   Port owner selector, word index and the client request and response bundles */
`include "mem_settings.svh"

package buffer_pkg;

	// Owner of the external Avalon port
	typedef enum logic [1:0] {
		SEL_READ1 = 2'b00, // Default read buffer
		SEL_READ2 = 2'b01, // Second read buffer, used when both are needed
		SEL_MASK = 2'b10,
		SEL_WRITEBACK = 2'b11
	} buf_sel_t;

	typedef logic [`MEM_IDX_W-1:0] buf_idx_t; // Word position within a burst

	// ########################################
	// Client request

	typedef struct packed {
		logic start; // Single-cycle strobe that launches a fetch
		avl_pkg::avl_addr_t addr; // Base word address of the fetch
		buf_idx_t idx; // Word shown on the response data
	} buf_req_t;

	// ########################################
	// Client response

	typedef struct packed {
		logic busy; // A transfer is in progress
		logic done; // One-cycle pulse at the end of a transfer
		avl_pkg::avl_data_t data; // Held word, valid while busy is low
	} buf_rsp_t;

endpackage

// File: verilog/read_buffer.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

/* Read buffer
   Fetches one burst of words over Avalon and serves them by index */
module read_buffer (
	input logic iCLK,
	input logic reset,
	input buffer_pkg::buf_req_t req,
	output buffer_pkg::buf_rsp_t rsp,
	output avl_pkg::avl_host_t avl_host,
	input avl_pkg::avl_agent_t avl_agent
);

	localparam buffer_pkg::buf_idx_t LAST_IDX = buffer_pkg::buf_idx_t'(`MEM_BURST_LEN - 1);

	typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} state_t;

	state_t state;
	avl_pkg::avl_addr_t base_addr; // Address of the first word
	buffer_pkg::buf_idx_t issue_cnt; // Read commands accepted so far
	buffer_pkg::buf_idx_t rx_cnt; // Words returned so far
	logic done_q;
	avl_pkg::avl_data_t words [`MEM_BURST_LEN];

	// ########################################
	// Command issue and data capture

	always_ff @(posedge iCLK) begin
		if (reset) begin
			state <= IDLE;
			base_addr <= '0;
			issue_cnt <= '0;
			rx_cnt <= '0;
			done_q <= 1'b0;
			for (int i = 0; i < `MEM_BURST_LEN; i++) begin
				words[i] <= '0;
			end
		end else begin
			done_q <= 1'b0;
			case (state)
				IDLE: begin
					if (req.start && avl_agent.local_init_done) begin // Strobe ignored otherwise
						base_addr <= req.addr;
						issue_cnt <= '0;
						rx_cnt <= '0;
						state <= ISSUE;
					end
				end
				ISSUE: begin
					if (avl_agent.wait_request_n) begin // Command accepted this cycle
						issue_cnt <= issue_cnt + 1'b1;
						if (issue_cnt == LAST_IDX)
							state <= DRAIN;
					end
				end
				default: begin
				end
			endcase

			// Data may return while later commands are still being issued
			if (state != IDLE && avl_agent.readdatavalid) begin
				words[rx_cnt] <= avl_agent.readdata;
				rx_cnt <= rx_cnt + 1'b1;
				if (rx_cnt == LAST_IDX) begin
					done_q <= 1'b1;
					state <= IDLE;
				end
			end
		end
	end

	always_comb begin
		avl_host.burstbegin = (state == ISSUE) && (issue_cnt == '0); // First command only
		avl_host.address = base_addr + avl_pkg::avl_addr_t'(issue_cnt);
		avl_host.writedata = '0;
		avl_host.write = 1'b0;
		avl_host.read = (state == ISSUE);
		rsp.busy = (state != IDLE);
		rsp.done = done_q;
		rsp.data = words[req.idx];
	end

endmodule

// File: verilog/mask_buffer.sv
`timescale 1ns/1ps

/* Mask buffer
   Fetches a single mask word over Avalon and holds it for the client */
module mask_buffer (
	input logic iCLK,
	input logic reset,
	input buffer_pkg::buf_req_t req,
	output buffer_pkg::buf_rsp_t rsp,
	output avl_pkg::avl_host_t avl_host,
	input avl_pkg::avl_agent_t avl_agent
);

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT} state_t;

	state_t state;
	avl_pkg::avl_addr_t mask_addr;
	avl_pkg::avl_data_t mask_q; // Last fetched mask
	logic done_q;

	// ########################################
	// Single read and capture

	always_ff @(posedge iCLK) begin
		if (reset) begin
			state <= IDLE;
			mask_addr <= '0;
			mask_q <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				IDLE: begin
					if (req.start && avl_agent.local_init_done) begin
						mask_addr <= req.addr;
						state <= ISSUE;
					end
				end
				ISSUE: begin
					if (avl_agent.wait_request_n) // Read accepted, now wait for the word
						state <= WAIT;
				end
				WAIT: begin
					if (avl_agent.readdatavalid) begin
						mask_q <= avl_agent.readdata;
						done_q <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		avl_host.burstbegin = (state == ISSUE); // A one-beat burst
		avl_host.address = mask_addr;
		avl_host.writedata = '0;
		avl_host.write = 1'b0;
		avl_host.read = (state == ISSUE);
		rsp.busy = (state != IDLE);
		rsp.done = done_q;
		rsp.data = mask_q;
	end

endmodule

// File: verilog/write_back_accumulator.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

/* Write-back accumulator
   Sums incoming words per index and writes the sums out as one Avalon burst */
module write_back_accumulator (
	input logic iCLK,
	input logic reset,
	input logic add,
	input buffer_pkg::buf_idx_t idx,
	input avl_pkg::avl_data_t word,
	input logic flush,
	input avl_pkg::avl_addr_t addr,
	output buffer_pkg::buf_rsp_t rsp,
	output avl_pkg::avl_host_t avl_host,
	input avl_pkg::avl_agent_t avl_agent
);

	localparam buffer_pkg::buf_idx_t LAST_IDX = buffer_pkg::buf_idx_t'(`MEM_BURST_LEN - 1);

	typedef enum logic {IDLE, WRITE} state_t;

	state_t state;
	avl_pkg::avl_addr_t base_addr;
	buffer_pkg::buf_idx_t beat; // Index of the sum on the bus
	logic done_q;
	avl_pkg::avl_data_t sums [`MEM_BURST_LEN];

	// ########################################
	// Accumulation

	always_ff @(posedge iCLK) begin
		if (reset) begin
			state <= IDLE;
			base_addr <= '0;
			beat <= '0;
			done_q <= 1'b0;
			for (int i = 0; i < `MEM_BURST_LEN; i++) begin
				sums[i] <= '0;
			end
		end else begin
			done_q <= 1'b0;
			case (state)
				IDLE: begin
					if (add)
						sums[idx] <= sums[idx] + word; // Wraps at the data width
					if (flush && avl_agent.local_init_done) begin
						base_addr <= addr;
						beat <= '0;
						state <= WRITE;
					end
				end

				// ########################################
				// Write-back burst

				WRITE: begin
					if (avl_agent.wait_request_n) begin // Beat accepted
						beat <= beat + 1'b1;
						if (beat == LAST_IDX) begin
							done_q <= 1'b1;
							state <= IDLE;
							for (int i = 0; i < `MEM_BURST_LEN; i++) begin
								sums[i] <= '0;
							end
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		avl_host.burstbegin = (state == WRITE) && (beat == '0);
		avl_host.address = base_addr + avl_pkg::avl_addr_t'(beat);
		avl_host.writedata = sums[beat];
		avl_host.write = (state == WRITE);
		avl_host.read = 1'b0;
		rsp.busy = (state != IDLE);
		rsp.done = done_q;
		rsp.data = sums[idx];
	end

endmodule

// File: verilog/mem_control.sv
`timescale 1ns/1ps

/* Memory control
   Holds the four buffers and hands the external Avalon port to the selected one */
module mem_control (
	input logic iCLK,
	input logic reset,
	input buffer_pkg::buf_sel_t selector,
	input buffer_pkg::buf_req_t rd1_req,
	output buffer_pkg::buf_rsp_t rd1_rsp,
	input buffer_pkg::buf_req_t rd2_req,
	output buffer_pkg::buf_rsp_t rd2_rsp,
	input buffer_pkg::buf_req_t mask_req,
	output buffer_pkg::buf_rsp_t mask_rsp,
	input logic acc_add,
	input buffer_pkg::buf_idx_t acc_idx,
	input avl_pkg::avl_data_t acc_word,
	input logic acc_flush,
	input avl_pkg::avl_addr_t acc_addr,
	output buffer_pkg::buf_rsp_t acc_rsp,
	output avl_pkg::avl_host_t ddr_host,
	input avl_pkg::avl_agent_t ddr_agent
);

	avl_pkg::avl_host_t rb1_host, rb2_host, mask_host, wba_host;
	avl_pkg::avl_agent_t rb1_agent, rb2_agent, mask_agent, wba_agent;
	avl_pkg::avl_agent_t stall_agent; // Seen by every buffer that does not own the port

	// ########################################
	// Buffers

	read_buffer rb1_i (
		.iCLK(iCLK), .reset(reset),
		.req(rd1_req), .rsp(rd1_rsp),
		.avl_host(rb1_host), .avl_agent(rb1_agent)
	);

	read_buffer rb2_i (
		.iCLK(iCLK), .reset(reset),
		.req(rd2_req), .rsp(rd2_rsp),
		.avl_host(rb2_host), .avl_agent(rb2_agent)
	);

	mask_buffer mb_i (
		.iCLK(iCLK), .reset(reset),
		.req(mask_req), .rsp(mask_rsp),
		.avl_host(mask_host), .avl_agent(mask_agent)
	);

	write_back_accumulator wba_i (
		.iCLK(iCLK), .reset(reset),
		.add(acc_add), .idx(acc_idx), .word(acc_word),
		.flush(acc_flush), .addr(acc_addr), .rsp(acc_rsp),
		.avl_host(wba_host), .avl_agent(wba_agent)
	);

	// ########################################
	// Port multiplexer

	always_comb begin
		stall_agent = '0; // wait_request_n low holds any pending command
		stall_agent.local_init_done = ddr_agent.local_init_done;
		rb1_agent = stall_agent;
		rb2_agent = stall_agent;
		mask_agent = stall_agent;
		wba_agent = stall_agent;
		ddr_host = '0;
		case (selector)
			buffer_pkg::SEL_READ1: begin
				ddr_host = rb1_host;
				rb1_agent = ddr_agent;
			end
			buffer_pkg::SEL_READ2: begin
				ddr_host = rb2_host;
				rb2_agent = ddr_agent;
			end
			buffer_pkg::SEL_MASK: begin
				ddr_host = mask_host;
				mask_agent = ddr_agent;
			end
			buffer_pkg::SEL_WRITEBACK: begin
				ddr_host = wba_host;
				wba_agent = ddr_agent;
			end
			default: ddr_host = '0;
		endcase
	end

endmodule

// File: verilog/mem_subsystem.sv
`timescale 1ns/1ps

/* Memory subsystem top level
   Connects the client ports and the DDR3 Avalon port to the memory control */
module mem_subsystem (
	input logic iCLK,
	input logic reset,
	input buffer_pkg::buf_sel_t selector, // Set externally, there is no arbitration
	input buffer_pkg::buf_req_t rd1_req,
	output buffer_pkg::buf_rsp_t rd1_rsp,
	input buffer_pkg::buf_req_t rd2_req,
	output buffer_pkg::buf_rsp_t rd2_rsp,
	input buffer_pkg::buf_req_t mask_req,
	output buffer_pkg::buf_rsp_t mask_rsp,
	input logic acc_add,
	input buffer_pkg::buf_idx_t acc_idx,
	input avl_pkg::avl_data_t acc_word,
	input logic acc_flush,
	input avl_pkg::avl_addr_t acc_addr,
	output buffer_pkg::buf_rsp_t acc_rsp,
	output avl_pkg::avl_host_t ddr_host, // Toward the DDR3 controller
	input avl_pkg::avl_agent_t ddr_agent
);

	mem_control mc_i (
		.iCLK(iCLK),
		.reset(reset),
		.selector(selector),
		.rd1_req(rd1_req), .rd1_rsp(rd1_rsp),
		.rd2_req(rd2_req), .rd2_rsp(rd2_rsp),
		.mask_req(mask_req), .mask_rsp(mask_rsp),
		.acc_add(acc_add),
		.acc_idx(acc_idx),
		.acc_word(acc_word),
		.acc_flush(acc_flush),
		.acc_addr(acc_addr),
		.acc_rsp(acc_rsp),
		.ddr_host(ddr_host),
		.ddr_agent(ddr_agent)
	);

endmodule

// File: test/avl_memory_model.sv
`timescale 1ns/1ps

/* Avalon memory model
   Stands in for the DDR3 controller with random wait states and a fixed read latency */
module avl_memory_model (
	input logic iCLK,
	input logic reset,
	input avl_pkg::avl_host_t host,
	output avl_pkg::avl_agent_t agent
);

	localparam int DEPTH = 256; // Words backed by storage, indexed by address[7:0]
	localparam int INIT_CYCLES = 10;
	localparam int READ_LAT = 3;

	avl_pkg::avl_data_t mem [DEPTH];
	avl_pkg::avl_data_t pipe_d [READ_LAT]; // Read return pipeline
	logic [READ_LAT-1:0] pipe_v;
	logic init_done_q;
	logic wrn_q;
	int init_cnt;
	integer seed;
	logic accept;

	initial begin
		seed = 67;
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = 32'hA500_0000 + i; // Preset word follows its address
		end
	end

	assign accept = wrn_q && (host.read || host.write);

	always @(posedge iCLK) begin
		if (reset) begin
			init_cnt <= 0;
			init_done_q <= 1'b0;
			wrn_q <= 1'b0;
			pipe_v <= '0;
		end else begin
			if (init_cnt < INIT_CYCLES)
				init_cnt <= init_cnt + 1;
			init_done_q <= (init_cnt >= INIT_CYCLES - 1); // Calibration takes 10 cycles
			wrn_q <= (($random(seed) & 3) != 0); // Stall about one cycle in four
			pipe_v <= {pipe_v[READ_LAT-2:0], accept && host.read};
			pipe_d[0] <= mem[host.address[7:0]];
			for (int i = 1; i < READ_LAT; i++) begin
				pipe_d[i] <= pipe_d[i-1];
			end
			if (accept && host.write)
				mem[host.address[7:0]] <= host.writedata;
		end
	end

	always_comb begin
		agent.local_init_done = init_done_q;
		agent.wait_request_n = wrn_q;
		agent.readdatavalid = pipe_v[READ_LAT-1]; // Returned in order, 3 cycles after accept
		agent.readdata = pipe_d[READ_LAT-1];
	end

endmodule

// File: test/mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

/* Memory subsystem testbench
   Runs fetches, accumulation and write-back against a behavioral Avalon memory */
module mem_subsystem_tb;

	localparam int TIMEOUT = 200; // Cycles allowed for any wait

	logic iCLK;
	logic reset;
	buffer_pkg::buf_sel_t selector;
	buffer_pkg::buf_req_t reqs [3]; // Read buffer 1, read buffer 2, mask buffer
	buffer_pkg::buf_rsp_t rsps [3];
	logic acc_add;
	buffer_pkg::buf_idx_t acc_idx;
	avl_pkg::avl_data_t acc_word;
	logic acc_flush;
	avl_pkg::avl_addr_t acc_addr;
	buffer_pkg::buf_rsp_t acc_rsp;
	avl_pkg::avl_host_t ddr_host;
	avl_pkg::avl_agent_t ddr_agent;

	avl_pkg::avl_data_t shadow [256]; // Words written back by flushes
	logic written [256];
	avl_pkg::avl_data_t acc_sums [`MEM_BURST_LEN];
	string name_q [$];
	avl_pkg::avl_data_t exp_q [$];
	avl_pkg::avl_data_t act_q [$];
	string cmp_name;
	avl_pkg::avl_data_t cmp_exp;
	avl_pkg::avl_data_t cmp_act;
	buffer_pkg::buf_idx_t add_idx;
	avl_pkg::avl_data_t add_word;
	int beats_left; // Beats still due in the current Avalon burst
	integer seed;

	mem_subsystem dut0 (
		.iCLK(iCLK), .reset(reset), .selector(selector),
		.rd1_req(reqs[0]), .rd1_rsp(rsps[0]),
		.rd2_req(reqs[1]), .rd2_rsp(rsps[1]),
		.mask_req(reqs[2]), .mask_rsp(rsps[2]),
		.acc_add(acc_add), .acc_idx(acc_idx), .acc_word(acc_word),
		.acc_flush(acc_flush), .acc_addr(acc_addr), .acc_rsp(acc_rsp),
		.ddr_host(ddr_host), .ddr_agent(ddr_agent)
	);

	avl_memory_model mem0 (.iCLK(iCLK), .reset(reset), .host(ddr_host), .agent(ddr_agent));

	initial iCLK = 1'b0;
	always #50 iCLK = ~iCLK;

	// ########################################
	// Reference model

	function automatic avl_pkg::avl_data_t mem_ref(input avl_pkg::avl_addr_t addr);
		if (written[addr[7:0]])
			return shadow[addr[7:0]]; // Overwritten by a flush
		return 32'hA500_0000 + addr;
	endfunction

	function automatic avl_pkg::avl_data_t acc_ref(input buffer_pkg::buf_idx_t idx);
		return acc_sums[idx];
	endfunction

	function automatic buffer_pkg::buf_rsp_t rsp_of(input int id);
		return (id < 3) ? rsps[id] : acc_rsp; // Id 3 is the accumulator
	endfunction

	// ########################################
	// Compare process

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic expect_word(input string name, input avl_pkg::avl_data_t exp,
			input avl_pkg::avl_data_t act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	always @(negedge iCLK) begin
		while (name_q.size() > 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp = exp_q.pop_front();
			cmp_act = act_q.pop_front();
			assert (cmp_act === cmp_exp)
			else fail_run($sformatf("Error %s expected %h actual %h", cmp_name, cmp_exp, cmp_act));
		end
	end

	// Every accepted beat carries burstbegin exactly when it opens a new burst
	always @(negedge iCLK) begin
		if (!reset && ddr_agent.wait_request_n && (ddr_host.read || ddr_host.write)) begin
			expect_word("burstbegin", avl_pkg::avl_data_t'(beats_left == 0),
				avl_pkg::avl_data_t'(ddr_host.burstbegin));
			if (beats_left == 0)
				beats_left = (selector == buffer_pkg::SEL_MASK) ? 0 : `MEM_BURST_LEN - 1;
			else
				beats_left--;
		end
	end

	// ########################################
	// Stimulus helpers

	task automatic wait_done(input int id);
		int n;
		buffer_pkg::buf_rsp_t cur;
		n = 0;
		do begin
			@(negedge iCLK);
			n++;
			if (n > TIMEOUT)
				fail_run($sformatf("Timed out waiting for done on client %0d", id));
			cur = rsp_of(id);
		end while (!cur.done);
		expect_word($sformatf("busy_at_done_%0d", id), '0,
			avl_pkg::avl_data_t'(cur.busy)); // Busy falls in the cycle that done pulses
	endtask

	task automatic pulse_start(input int id, input avl_pkg::avl_addr_t addr);
		@(posedge iCLK);
		reqs[id].start <= 1'b1;
		reqs[id].addr <= addr;
		@(posedge iCLK);
		reqs[id].start <= 1'b0;
	endtask

	task automatic check_words(input int id, input avl_pkg::avl_addr_t base, input string name);
		for (int i = 0; i < `MEM_BURST_LEN; i++) begin
			@(posedge iCLK);
			if (id < 3)
				reqs[id].idx <= buffer_pkg::buf_idx_t'(i);
			else
				acc_idx <= buffer_pkg::buf_idx_t'(i);
			@(negedge iCLK);
			if (id < 3)
				expect_word(name, mem_ref(base + i), rsps[id].data);
			else
				expect_word(name, acc_ref(buffer_pkg::buf_idx_t'(i)), acc_rsp.data);
		end
	endtask

	task automatic wait_init();
		int n;
		n = 0;
		while (!ddr_agent.local_init_done) begin
			@(negedge iCLK);
			n++;
			if (n > TIMEOUT)
				fail_run("Memory never reported init done");
		end
	endtask

	task automatic wait_checks();
		int n;
		n = 0;
		while (name_q.size() > 0) begin
			@(negedge iCLK);
			n++;
			if (n > TIMEOUT)
				fail_run("Pending comparisons were never evaluated");
		end
	endtask

	// ########################################
	// Test sequence

	initial begin
		seed = 67;
		beats_left = 0;
		reset = 1'b1;
		selector = buffer_pkg::SEL_READ1;
		for (int i = 0; i < 3; i++) begin
			reqs[i] = '0;
		end
		acc_add = 1'b0;
		acc_idx = '0;
		acc_word = '0;
		acc_flush = 1'b0;
		acc_addr = '0;
		for (int i = 0; i < 256; i++) begin
			written[i] = 1'b0;
		end
		for (int i = 0; i < `MEM_BURST_LEN; i++) begin
			acc_sums[i] = '0;
		end
		repeat (2) @(posedge iCLK);
		reset <= 1'b0;
		wait_init();

		pulse_start(0, 16); // Read buffer 1 owns the port
		wait_done(0);
		check_words(0, 16, "read1");

		@(posedge iCLK);
		selector <= buffer_pkg::SEL_READ2;
		pulse_start(1, 40);
		wait_done(1);
		check_words(1, 40, "read2");
		check_words(0, 16, "read1_hold");

		@(posedge iCLK);
		selector <= buffer_pkg::SEL_MASK;
		pulse_start(2, 7);
		wait_done(2);
		@(negedge iCLK);
		expect_word("mask", mem_ref(7), rsps[2].data);

		for (int n = 0; n < 8; n++) begin
			add_idx = buffer_pkg::buf_idx_t'($random(seed));
			add_word = $random(seed);
			@(posedge iCLK);
			acc_add <= 1'b1;
			acc_idx <= add_idx;
			acc_word <= add_word;
			acc_sums[add_idx] = acc_sums[add_idx] + add_word; // Wraps like the DUT
			@(posedge iCLK);
			acc_add <= 1'b0;
			@(negedge iCLK);
			expect_word("acc_add", acc_ref(add_idx), acc_rsp.data);
		end

		@(posedge iCLK);
		selector <= buffer_pkg::SEL_WRITEBACK;
		acc_flush <= 1'b1;
		acc_addr <= 64;
		@(posedge iCLK);
		acc_flush <= 1'b0;
		wait_done(3);
		for (int i = 0; i < `MEM_BURST_LEN; i++) begin
			shadow[64 + i] = acc_sums[i];
			written[64 + i] = 1'b1;
			acc_sums[i] = '0; // Sums clear once the burst is written
		end
		check_words(3, 0, "acc_clear");
		@(posedge iCLK);
		selector <= buffer_pkg::SEL_READ1;
		pulse_start(0, 64);
		wait_done(0);
		check_words(0, 64, "read1_flushed");

		// Read buffer 2 stalls while the mask buffer owns the port
		@(posedge iCLK);
		selector <= buffer_pkg::SEL_MASK;
		pulse_start(1, 48);
		repeat (50) begin
			@(negedge iCLK);
			expect_word("read2_stall", '0, avl_pkg::avl_data_t'(rsps[1].done));
		end
		@(posedge iCLK);
		selector <= buffer_pkg::SEL_READ2;
		wait_done(1);
		check_words(1, 48, "read2_late");

		@(posedge iCLK);
		selector <= buffer_pkg::SEL_READ1;
		pulse_start(0, 100);
		@(negedge iCLK);
		expect_word("read1_busy", 1, avl_pkg::avl_data_t'(rsps[0].busy));
		pulse_start(0, 200); // Must be ignored
		wait_done(0);
		check_words(0, 100, "read1_restart");

		wait_checks();
		$display("All checks passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+verilog
verilog/avl_pkg.sv
verilog/buffer_pkg.sv
verilog/read_buffer.sv
verilog/mask_buffer.sv
verilog/write_back_accumulator.sv
verilog/mem_control.sv
verilog/mem_subsystem.sv
test/avl_memory_model.sv
test/mem_subsystem_tb.sv
